// File: test/rename_golden.txt
# req0 v d s1 s2, req1 | wb0 v a p, wb1 | ret0 v d new old, ret1 | flush
# expected resp0 s1p s1r s2p s2r new old, resp1 | stall
1 5 1 2 1 7 3 4 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 1 1 2 1 32 5 3 1 4 1 33 7 | 0
1 8 5 7 1 9 8 8 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 32 0 33 0 34 8 34 0 34 0 35 9 | 0
1 10 0 0 1 10 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 36 10 0 1 0 1 37 36 | 0
1 11 5 7 0 0 0 0 | 1 5 32 1 7 40 | 0 0 0 0 0 0 0 0 | 0 | 32 1 33 0 38 11 0 0 0 0 0 0 | 0
1 12 5 7 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 32 1 33 0 39 12 0 0 0 0 0 0 | 0
1 0 0 5 1 13 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 32 1 0 0 0 1 0 1 40 13 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 41 14 0 1 0 1 42 15 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 43 41 0 1 0 1 44 42 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 45 43 0 1 0 1 46 44 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 47 45 0 1 0 1 48 46 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 49 47 0 1 0 1 50 48 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 51 49 0 1 0 1 52 50 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 53 51 0 1 0 1 54 52 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 55 53 0 1 0 1 56 54 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 57 55 0 1 0 1 58 56 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 59 57 0 1 0 1 60 58 | 0
1 14 0 0 1 15 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 61 59 0 1 0 1 62 60 | 0
1 16 0 0 1 17 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 0 0 0 0 0 0 0 0 0 0 0 | 1
1 16 0 0 1 17 0 0 | 0 0 0 0 0 0 | 1 5 32 5 1 7 33 7 | 0 | 0 0 0 0 0 0 0 0 0 0 0 0 | 1
1 16 0 0 1 17 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 1 0 1 5 16 0 1 0 1 7 17 | 0
1 18 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 0 0 0 0 0 0 0 | 0
1 18 5 7 1 19 1 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 32 1 33 1 5 18 1 1 0 1 7 19 | 0
1 20 18 8 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 5 0 8 1 34 20 0 0 0 0 0 0 | 0
1 0 18 0 1 21 0 18 | 1 18 5 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 5 1 0 1 0 0 0 1 5 1 35 21 | 0
0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 | 0 | 0 0 0 0 0 0 0 0 0 0 0 0 | 0

// File: filelist.f
src/rename_pkg.sv
src/map_table.sv
src/free_list.sv
src/arch_map.sv
src/rename_top.sv
test/rename_checker.sv
test/rename_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
GOLDEN    ?= test/rename_golden.txt
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(GOLDEN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: test/rename_tb.sv
module rename_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int lanes = rename_pkg::width;
    // req, wb, retire, flush, resp, stall
    localparam int n_cols = 17 * lanes + 2;
    localparam int max_rows = 128;
    localparam string golden_path = "test/rename_golden.txt";

    logic clock;
    logic reset;
    logic flush;
    logic stall;
    rename_pkg::rename_req_t  [lanes-1:0] req;
    rename_pkg::wb_t          [lanes-1:0] wb;
    rename_pkg::retire_t      [lanes-1:0] retire;
    rename_pkg::rename_resp_t [lanes-1:0] resp;

    // one row per cycle
    int golden [max_rows][n_cols];
    int n_rows;
    int cycle_count;
    int cycle_limit;

    rename_top #(
        .arch_regs (rename_pkg::arch_regs),
        .phys_regs (rename_pkg::phys_regs),
        .width     (lanes)
    ) u_dut (
        .clock     (clock),
        .reset     (reset),
        .req       (req),
        .wb        (wb),
        .retire    (retire),
        .flush     (flush),
        .resp      (resp),
        .stall     (stall)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // run limit comes from the row count once the file is loaded
    initial cycle_count = 0;
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
            $display("timeout, the run went past %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d",
                     $time, name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // a bound assertion that fired leaves its count behind
    task automatic check_assertions();
        if (u_dut.u_checker.assert_failures != 0) begin
            $display("a bound assertion failed at %0t, %0d failures so far",
                     $time, u_dut.u_checker.assert_failures);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // pull decimal numbers out of a line, anything else separates them
    task automatic parse_line(input string line, input int row, output int count);
        byte ch;
        int  value;
        bit  in_num;
        count  = 0;
        value  = 0;
        in_num = 1'b0;
        for (int i = 0; i <= line.len(); i++) begin
            ch = (i < line.len()) ? line.getc(i) : 8'h20;
            if ((ch >= "0") && (ch <= "9")) begin
                value  = value * 10 + int'(ch - "0");
                in_num = 1'b1;
            end else if (in_num) begin
                if (count < n_cols) begin
                    golden[row][count] = value;
                end
                count++;
                value  = 0;
                in_num = 1'b0;
            end
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    count;
        string line;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", golden_path);
            $display("ERRORS FOUND");
            $fatal(1);
        end
        n_rows = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // comment lines start with a hash
            if ((line.len() > 0) && (line.getc(0) != "#")) begin
                parse_line(line, n_rows, count);
                if ((count != 0) && ((count != n_cols) || (n_rows >= max_rows - 1))) begin
                    $display("stimulus row %0d is malformed or the file is too long", n_rows);
                    $display("ERRORS FOUND");
                    $fatal(1);
                end
                if (count == n_cols) begin
                    n_rows++;
                end
            end
        end
        $fclose(fd);
        if (n_rows == 0) begin
            $display("the stimulus file holds no rows");
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic apply_row(input int r);
        int b;
        for (int l = 0; l < lanes; l++) begin
            b = 4 * l;
            req[l].valid = 1'(golden[r][b]);
            req[l].dest  = rename_pkg::arch_idx_t'(golden[r][b + 1]);
            req[l].src1  = rename_pkg::arch_idx_t'(golden[r][b + 2]);
            req[l].src2  = rename_pkg::arch_idx_t'(golden[r][b + 3]);
            b = 4 * lanes + 3 * l;
            wb[l].valid  = 1'(golden[r][b]);
            wb[l].arch   = rename_pkg::arch_idx_t'(golden[r][b + 1]);
            wb[l].phys   = rename_pkg::phys_idx_t'(golden[r][b + 2]);
            b = 7 * lanes + 4 * l;
            retire[l].valid    = 1'(golden[r][b]);
            retire[l].dest     = rename_pkg::arch_idx_t'(golden[r][b + 1]);
            retire[l].new_phys = rename_pkg::phys_idx_t'(golden[r][b + 2]);
            retire[l].old_phys = rename_pkg::phys_idx_t'(golden[r][b + 3]);
        end
        flush = 1'(golden[r][11 * lanes]);
    endtask

    task automatic check_row(input int r);
        int b;
        for (int l = 0; l < lanes; l++) begin
            b = 11 * lanes + 1 + 6 * l;
            check_value($sformatf("row %0d resp[%0d].src1.phys", r, l),
                        int'(resp[l].src1.phys), golden[r][b]);
            check_value($sformatf("row %0d resp[%0d].src1.ready", r, l),
                        int'(resp[l].src1.ready), golden[r][b + 1]);
            check_value($sformatf("row %0d resp[%0d].src2.phys", r, l),
                        int'(resp[l].src2.phys), golden[r][b + 2]);
            check_value($sformatf("row %0d resp[%0d].src2.ready", r, l),
                        int'(resp[l].src2.ready), golden[r][b + 3]);
            check_value($sformatf("row %0d resp[%0d].new_phys", r, l),
                        int'(resp[l].new_phys), golden[r][b + 4]);
            check_value($sformatf("row %0d resp[%0d].old_phys", r, l),
                        int'(resp[l].old_phys), golden[r][b + 5]);
        end
        check_value($sformatf("row %0d stall", r), int'(stall), golden[r][17 * lanes + 1]);
    endtask

    initial begin
        reset       = 1'b1;
        flush       = 1'b0;
        req         = '0;
        wb          = '0;
        retire      = '0;
        cycle_limit = 0;
        load_golden();
        cycle_limit = n_rows + 20;
        repeat (3) @(posedge clock);
        // drive just after the edge, sample just before the next
        for (int r = 0; r < n_rows; r++) begin
            #1;
            check_assertions();
            reset = 1'b0;
            apply_row(r);
            #7;
            check_row(r);
            @(posedge clock);
        end
        // assertions of the last edge
        #1;
        check_assertions();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: test/rename_checker.sv
module rename_checker #(
    parameter int width = rename_pkg::width
) (
    input logic                                   clock,
    input logic                                   reset,
    input logic                     [width-1:0]   need_reg,
    input rename_pkg::phys_idx_t    [width-1:0]   alloc,
    input logic                                   flush,
    input logic                                   stall,
    input rename_pkg::rename_resp_t [width-1:0]   resp
);
    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions so far
    int assert_failures = 0;

    // every lane that takes a register gets a nonzero one, no two alike
    function automatic logic picks_ok(
        input logic                  [width-1:0] need,
        input rename_pkg::phys_idx_t [width-1:0] picks
    );
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < width; i++) begin
            if (need[i] && (picks[i] == '0)) begin
                ok = 1'b0;
            end
            for (int j = i + 1; j < width; j++) begin
                if (need[i] && need[j] && (picks[i] == picks[j])) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    // picks only matter when the group goes ahead
    alloc_distinct: assert property (@(posedge clock) disable iff (reset)
        !stall |-> picks_ok(need_reg, alloc))
        else begin
            assert_failures++;
            $error("allocation gave phys 0 or the same phys to two lanes");
        end

    // a held group shows nothing
    stall_quiet: assert property (@(posedge clock) disable iff (reset)
        stall |-> (resp == '0))
        else begin
            assert_failures++;
            $error("resp not zero while stalled");
        end

    // rebuilt free list always covers a full group
    flush_unstalls: assert property (@(posedge clock) disable iff (reset)
        flush |=> !stall)
        else begin
            assert_failures++;
            $error("stall high in the cycle after a flush");
        end

endmodule

bind rename_top rename_checker #(
    .width    (width)
) u_checker (
    .clock    (clock),
    .reset    (reset),
    .need_reg (need_reg),
    .alloc    (alloc),
    .flush    (flush),
    .stall    (stall),
    .resp     (resp)
);

// File: src/rename_top.sv
module rename_top #(
    parameter int arch_regs = rename_pkg::arch_regs,
    parameter int phys_regs = rename_pkg::phys_regs,
    parameter int width     = rename_pkg::width
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  rename_pkg::rename_req_t    [width-1:0]      req,
    // completions from the execution units
    input  rename_pkg::wb_t            [width-1:0]      wb,
    // commits from the reorder buffer
    input  rename_pkg::retire_t        [width-1:0]      retire,
    input  logic                                        flush,
    output rename_pkg::rename_resp_t   [width-1:0]      resp,
    // group could not get enough registers
    output logic                                        stall
);

    // raw valid bits of the group
    logic [width-1:0] req_valid;
    // lanes that need a fresh register
    logic [width-1:0] need_reg;
    // lanes allowed to rename this cycle
    logic [width-1:0] accepted;

    rename_pkg::phys_idx_t  [width-1:0]     alloc;
    rename_pkg::map_entry_t [arch_regs-1:0] committed_map;

    always_comb begin
        for (int i = 0; i < width; i++) begin
            req_valid[i] = req[i].valid;
            // dest arch 0 is never remapped, so it takes no register
            need_reg[i]  = req[i].valid && (req[i].dest != '0);
        end
    end

    // stalled or flushed groups do nothing
    assign accepted = req_valid & {width{~(stall | flush)}};

    map_table #(
        .arch_regs (arch_regs),
        .phys_regs (phys_regs),
        .width     (width)
    ) u_map_table (
        .clock     (clock),
        .reset     (reset),
        .req_valid (accepted),
        .req       (req),
        .alloc     (alloc),
        .wb        (wb),
        // flush restores the committed state at the next edge
        .load_en   (flush),
        .load_map  (committed_map),
        .resp      (resp)
    );

    free_list #(
        .arch_regs       (arch_regs),
        .phys_regs       (phys_regs),
        .width           (width)
    ) u_free_list (
        .clock           (clock),
        .reset           (reset),
        .req_count_valid (need_reg),
        .flush           (flush),
        .committed_map   (committed_map),
        .retire          (retire),
        .alloc           (alloc),
        .stall           (stall)
    );

    arch_map #(
        .arch_regs     (arch_regs),
        .phys_regs     (phys_regs),
        .width         (width)
    ) u_arch_map (
        .clock         (clock),
        .reset         (reset),
        .retire        (retire),
        .committed_map (committed_map)
    );

endmodule

// File: src/arch_map.sv
module arch_map #(
    parameter int arch_regs = rename_pkg::arch_regs,
    parameter int phys_regs = rename_pkg::phys_regs,
    parameter int width     = rename_pkg::width
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  rename_pkg::retire_t        [width-1:0]      retire,
    // retired state, the recovery point on flush
    output rename_pkg::map_entry_t     [arch_regs-1:0]  committed_map
);

    // committed phys per arch reg
    rename_pkg::phys_idx_t [arch_regs-1:0] committed;
    rename_pkg::phys_idx_t [arch_regs-1:0] next_committed;

    // later lanes overwrite earlier ones on the same dest
    always_comb begin
        next_committed = committed;
        for (int r = 0; r < width; r++) begin
            // arch 0 keeps phys 0
            if (retire[r].valid && (retire[r].dest != '0)) begin
                next_committed[retire[r].dest] = retire[r].new_phys;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // same identity map as the speculative table
            for (int a = 0; a < arch_regs; a++) begin
                committed[a] <= rename_pkg::phys_idx_t'(a);
            end
        end else begin
            committed <= next_committed;
        end
    end

    // every retired value has been written, so all ready
    always_comb begin
        for (int a = 0; a < arch_regs; a++) begin
            committed_map[a].phys  = committed[a];
            committed_map[a].ready = 1'b1;
        end
    end

    // identity reset needs at least as many phys as arch regs
    initial begin
        if (phys_regs <= arch_regs) begin
            $error("need more phys regs (%0d) than arch regs (%0d)", phys_regs, arch_regs);
        end
    end

endmodule

// File: src/free_list.sv
module free_list #(
    parameter int arch_regs = rename_pkg::arch_regs,
    parameter int phys_regs = rename_pkg::phys_regs,
    parameter int width     = rename_pkg::width
) (
    input  logic                                        clock,
    input  logic                                        reset,
    // lanes that need a destination register
    input  logic                       [width-1:0]      req_count_valid,
    input  logic                                        flush,
    input  rename_pkg::map_entry_t     [arch_regs-1:0]  committed_map,
    input  rename_pkg::retire_t        [width-1:0]      retire,
    output rename_pkg::phys_idx_t      [width-1:0]      alloc,
    output logic                                        stall
);

    // one bit per phys reg, set when free
    logic [phys_regs-1:0] free_bits;
    // bitmap left after this cycle's picks
    logic [phys_regs-1:0] avail;
    logic [phys_regs-1:0] next_free;
    // per lane hit in the chained search
    logic [width-1:0]     lane_found;

    // chained priority search, each lane takes the lowest bit left over
    always_comb begin
        avail      = free_bits;
        alloc      = '0;
        lane_found = '0;
        for (int k = 0; k < width; k++) begin
            if (req_count_valid[k]) begin
                // phys 0 is never handed out
                for (int p = 1; p < phys_regs; p++) begin
                    if (!lane_found[k] && avail[p]) begin
                        lane_found[k] = 1'b1;
                        alloc[k]      = rename_pkg::phys_idx_t'(p);
                    end
                end
                if (lane_found[k]) begin
                    avail[alloc[k]] = 1'b0;
                end
            end
        end
    end

    // a requesting lane without a hit means too few free registers
    assign stall = |(req_count_valid & ~lane_found);

    always_comb begin
        if (flush) begin
            // rebuild, free is whatever the committed map does not hold
            next_free    = '1;
            next_free[0] = 1'b0;
            for (int a = 0; a < arch_regs; a++) begin
                next_free[committed_map[a].phys] = 1'b0;
            end
        end else if (stall) begin
            // whole group held back, nothing consumed
            next_free = free_bits;
        end else begin
            next_free = avail;
        end

        // retires in lane order
        for (int r = 0; r < width; r++) begin
            if (retire[r].valid) begin
                // committed map still shows the pre-retire mapping during flush
                if (flush && (retire[r].dest != '0)) begin
                    next_free[retire[r].new_phys] = 1'b0;
                end
                if (retire[r].old_phys != '0) begin
                    next_free[retire[r].old_phys] = 1'b1;
                end
            end
        end
    end

    // arch regs start on the low phys regs, the rest are free
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < phys_regs; i++) begin
                free_bits[i] <= (i >= arch_regs);
            end
        end else begin
            free_bits <= next_free;
        end
    end

endmodule

// File: src/map_table.sv
module map_table #(
    parameter int arch_regs = rename_pkg::arch_regs,
    parameter int phys_regs = rename_pkg::phys_regs,
    parameter int width     = rename_pkg::width
) (
    input  logic                                        clock,
    input  logic                                        reset,
    // lanes already gated by stall and flush
    input  logic                       [width-1:0]      req_valid,
    input  rename_pkg::rename_req_t    [width-1:0]      req,
    // fresh registers, one per lane
    input  rename_pkg::phys_idx_t      [width-1:0]      alloc,
    input  rename_pkg::wb_t            [width-1:0]      wb,
    // recovery copy from the committed map
    input  logic                                        load_en,
    input  rename_pkg::map_entry_t     [arch_regs-1:0]  load_map,
    output rename_pkg::rename_resp_t   [width-1:0]      resp
);

    // speculative arch to phys mapping
    rename_pkg::map_entry_t [arch_regs-1:0] entries;
    rename_pkg::map_entry_t [arch_regs-1:0] next_entries;

    always_comb begin
        // recovery replaces the whole table first
        if (load_en) begin
            next_entries = load_map;
        end else begin
            next_entries = entries;
        end
        resp = '0;

        // completions land before lookups, gives same cycle bypass
        for (int w = 0; w < width; w++) begin
            // stale tag means the arch reg was renamed again
            if (wb[w].valid && (wb[w].phys != '0) &&
                (next_entries[wb[w].arch].phys == wb[w].phys)) begin
                next_entries[wb[w].arch].ready = 1'b1;
            end
        end

        // lanes in program order
        for (int i = 0; i < width; i++) begin
            if (req_valid[i]) begin
                // sources see renames of older lanes in the group
                resp[i].src1     = next_entries[req[i].src1];
                resp[i].src2     = next_entries[req[i].src2];
                // old mapping goes back to the free list at retire
                resp[i].old_phys = next_entries[req[i].dest].phys;

                // arch 0 stays pinned to phys 0
                if (req[i].dest != '0) begin
                    resp[i].new_phys = alloc[i];
                    next_entries[req[i].dest].phys  = alloc[i];
                    next_entries[req[i].dest].ready = 1'b0;
                end
            end
        end
    end

    // identity map out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < arch_regs; a++) begin
                entries[a].phys  <= rename_pkg::phys_idx_t'(a);
                entries[a].ready <= 1'b1;
            end
        end else begin
            entries <= next_entries;
        end
    end

    // phys_regs only sizes the packed phys index in the package
    localparam int phys_bits = $bits(rename_pkg::phys_idx_t);
    initial begin
        if ((1 << phys_bits) < phys_regs) begin
            $error("phys index too narrow for %0d registers", phys_regs);
        end
    end

endmodule

// File: src/rename_pkg.sv
package rename_pkg;

    // core sizing
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;
    // renames per cycle
    localparam int width = 2;

    localparam int arch_idx_bits = $clog2(arch_regs);
    localparam int phys_idx_bits = $clog2(phys_regs);

    typedef logic [arch_idx_bits-1:0] arch_idx_t;
    typedef logic [phys_idx_bits-1:0] phys_idx_t;

    // one map slot, phys 0 is the hardwired zero register
    typedef struct packed {
        phys_idx_t phys;
        logic      ready;
    } map_entry_t;

    // decoded instruction entering rename
    typedef struct packed {
        logic      valid;
        arch_idx_t dest;
        arch_idx_t src1;
        arch_idx_t src2;
    } rename_req_t;

    // renamed operands and destination
    typedef struct packed {
        map_entry_t src1;
        map_entry_t src2;
        phys_idx_t  new_phys;
        // freed once this instruction retires
        phys_idx_t  old_phys;
    } rename_resp_t;

    // result broadcast from an execution unit
    typedef struct packed {
        logic      valid;
        arch_idx_t arch;
        phys_idx_t phys;
    } wb_t;

    // commit from the reorder buffer
    typedef struct packed {
        logic      valid;
        arch_idx_t dest;
        phys_idx_t new_phys;
        phys_idx_t old_phys;
    } retire_t;

endpackage
